//--- sdInit_stimulus.txt
# name fault busyCount rca(hex) expDone expErr
normal none 0 1234 1 0
retry3 none 3 BEEF 1 0
retry1 none 1 0001 1 0
echoFault badEcho 0 5A5A 0 1
crcFault badCrc 0 5A5A 0 1
stopFault badStop 0 5A5A 0 1
transFault badTransBit 0 5A5A 0 1

//--- compile.f
+incdir+.
sdInitPkg.sv
crc7.sv
sdClockGen.sv
cmdEngine.sv
initSequencer.sv
sdCardInitializer.sv
sdInit_properties.sv
tbSdCardInitializer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module tbSdCardInitializer -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- tbSdCardInitializer.sv
// Testbench for the SD card initializer
// Reads one scenario per line from the stimulus file, runs a behavioral
// card on the CMD line and checks framing, order, arguments and gaps.
`timescale 1ns/100ps
`include "sdInit_cfg.svh"

module tbSdCardInitializer;
    logic        clk;
    logic        arstN;
    logic        cardOe;
    logic        cardBit;
    wire         sdCmdIn;
    logic        sdClk, sdCmdOut, sdCmdOe, done, err;
    logic [15:0] rca;

    // Scenario table
    logic [127:0] nameArr[16];
    logic [127:0] faultArr[16];
    int           busyArr[16], expDoneArr[16], expErrArr[16];
    logic [15:0]  rcaArr[16];
    int           numScen;
    longint       cycles, cycleLimit;
    int           errCount;

    // Card model state, reset per scenario
    logic [127:0] scenName, faultKind;
    int           busyCount, busyLeft, frameNo, cmd41Cnt, idleClks;
    logic [15:0]  scenRca;
    logic [5:0]   expIdx;
    logic         selPhase, faultPending;

    // Open-drain style line with pull-up
    assign sdCmdIn = sdCmdOe ? sdCmdOut : (cardOe ? cardBit : 1'b1);

    sdCardInitializer dut0 (
        .clk(clk), .arstN(arstN), .sdCmdIn(sdCmdIn), .sdClk(sdClk), .sdCmdOut(sdCmdOut),
        .sdCmdOe(sdCmdOe), .rca(rca), .done(done), .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = !clk;
    end

    task automatic failRun(input string msg);
        $display("%0s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkValue(input string label, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errCount++;
            $display("mismatch %0s %0s: expected %0h, actual %0h", scenName, label, exp, act);
            failRun("check failed");
        end
    endtask

    // CRC7, x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7Of(input logic [39:0] d);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = d[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) c = c ^ 7'h09;
        end
        return c;
    endfunction

    function automatic logic [47:0] shortResp(input logic [5:0] idx, input logic [31:0] a);
        logic [39:0] h;
        h = {2'b00, idx, a};
        return {h, crc7Of(h), 1'b1};
    endfunction

    // ==================================================
    // Card model
    // ==================================================
    task automatic receiveFrame(output logic [47:0] f);
        @(posedge sdClk);
        while (sdCmdIn !== 1'b0) begin
            idleClks++;
            @(posedge sdClk);
        end
        f[47] = 1'b0;
        for (int i = 46; i >= 0; i--) begin
            @(posedge sdClk);
            f[i] = sdCmdIn;
        end
    endtask

    task automatic sendResponse(input logic [135:0] r, input int len);
        // Two idle card clocks before the start bit
        repeat (2) @(negedge sdClk);
        for (int i = len - 1; i >= 0; i--) begin
            @(negedge sdClk);
            #1;
            // Host must have released the line while the card talks
            checkValue("lineFree", 0, sdCmdOe);
            cardOe  = 1'b1;
            cardBit = r[i];
        end
        @(negedge sdClk);
        #1;
        cardOe  = 1'b0;
        cardBit = 1'b1;
    endtask

    task automatic handleFrame(input logic [47:0] f);
        logic [5:0]   idx;
        logic [31:0]  arg;
        logic [39:0]  h;
        logic [47:0]  r;
        logic [127:0] cid;
        logic         ready;
        idx = f[45:40];
        arg = f[39:8];
        if (frameNo > 0) checkValue("gap", 1, idleClks >= `GAP_CLKS);
        frameNo++;
        checkValue("startTrans", 2'b01, f[47:46]);
        checkValue("cmdCrc", crc7Of(f[47:8]), f[7:1]);
        checkValue("endBit", 1, f[0]);
        checkValue("cmdIndex", expIdx, idx);
        case (idx)
            6'd0: expIdx = 6'd8;
            6'd8: begin
                checkValue("cmd8Arg", `ARG_IF_COND, arg);
                r = shortResp(6'd8, arg);
                if (faultPending) begin
                    faultPending = 1'b0;
                    if (faultKind == "badEcho") r = shortResp(6'd8, {arg[31:8], ~arg[7:0]});
                    if (faultKind == "badCrc") r[1] = !r[1];
                    if (faultKind == "badStop") r[0] = 1'b0;
                    if (faultKind == "badTransBit") begin
                        h = {2'b01, 6'd8, arg};
                        r = {h, crc7Of(h), 1'b1};
                    end
                end
                sendResponse(r, 48);
                expIdx = 6'd55;
            end
            6'd55: begin
                if (selPhase) begin
                    checkValue("cmd55Arg", {scenRca, 16'h0}, arg);
                    expIdx = 6'd6;
                end else begin
                    expIdx = 6'd41;
                end
                sendResponse(shortResp(6'd55, 32'h0000_0120), 48);
            end
            6'd41: begin
                checkValue("cmd41Arg", `ARG_OP_COND, arg);
                cmd41Cnt++;
                ready = (busyLeft == 0);
                if (!ready) busyLeft--;
                // R3 with all ones in index and CRC fields
                sendResponse({2'b00, 6'h3F, ready, 7'h40, 24'hFF8000, 7'h7F, 1'b1}, 48);
                expIdx = ready ? 6'd2 : 6'd55;
            end
            6'd2: begin
                checkValue("cmd41Count", busyCount + 1, cmd41Cnt);
                cid = {$urandom, $urandom, $urandom, $urandom};
                sendResponse({2'b00, 6'h3F, cid[126:0], 1'b1}, `LONG_RESP_BITS);
                expIdx = 6'd3;
            end
            6'd3: begin
                sendResponse(shortResp(6'd3, {scenRca, 16'h0500}), 48);
                expIdx = 6'd7;
            end
            6'd7: begin
                checkValue("cmd7Arg", {scenRca, 16'h0}, arg);
                selPhase = 1'b1;
                sendResponse(shortResp(6'd7, 32'h0000_0700), 48);
                expIdx = 6'd55;
            end
            6'd6: begin
                checkValue("acmd6Arg", `ARG_BUS_WIDTH4, arg);
                sendResponse(shortResp(6'd6, 32'h0000_0920), 48);
                expIdx = 6'h3F;
            end
            default: failRun("card model received a command it does not know");
        endcase
        idleClks = 0;
    endtask

    initial begin : cardModel
        logic [47:0] f;
        cardOe  = 1'b0;
        cardBit = 1'b1;
        forever begin
            receiveFrame(f);
            handleFrame(f);
        end
    end

    // Run length limit in clk cycles
    always @(posedge clk) begin
        if (cycleLimit != 0) begin
            cycles++;
            if (cycles > cycleLimit) failRun("timeout: the initializer did not finish in time");
        end
    end

    // ==================================================
    // Scenario loop
    // ==================================================
    task automatic runScenario(input int s);
        int frozen;
        scenName     = nameArr[s];
        faultKind    = faultArr[s];
        busyCount    = busyArr[s];
        busyLeft     = busyArr[s];
        scenRca      = rcaArr[s];
        frameNo      = 0;
        cmd41Cnt     = 0;
        idleClks     = 0;
        expIdx       = 6'd0;
        selPhase     = 1'b0;
        faultPending = (faultArr[s] != "none");
        @(posedge clk);
        #1 arstN = 1'b0;
        repeat (10) @(posedge clk);
        // Outputs sit at their reset values before release
        checkValue("resetOe", 0, sdCmdOe);
        checkValue("resetOut", 1, sdCmdOut);
        checkValue("resetRca", 0, rca);
        checkValue("resetDone", 0, done);
        checkValue("resetErr", 0, err);
        #1 arstN = 1'b1;
        while (!done && !err) @(negedge clk);
        checkValue("done", expDoneArr[s], done);
        checkValue("err", expErrArr[s], err);
        if (expDoneArr[s] != 0) begin
            checkValue("rca", scenRca, rca);
            checkValue("lastCmd", 6'h3F, expIdx);
        end
        if (err) begin
            frozen = frameNo;
            repeat (200) @(posedge sdClk);
            checkValue("framesAfterErr", frozen, frameNo);
            checkValue("doneAfterErr", 0, done);
        end
    endtask

    initial begin : mainRun
        int           fd;
        logic [1023:0] header;
        arstN      = 1'b0;
        cycles     = 0;
        cycleLimit = 0;
        errCount   = 0;
        numScen    = 0;
        scenName   = "setup";
        void'($urandom(32'h0338_5544));
        fd = $fopen("sdInit_stimulus.txt", "r");
        if (fd == 0) failRun("could not open the stimulus file");
        void'($fgets(header, fd));
        while (numScen < 16 && $fscanf(fd, "%s %s %d %h %d %d\n", nameArr[numScen],
                faultArr[numScen], busyArr[numScen], rcaArr[numScen],
                expDoneArr[numScen], expErrArr[numScen]) == 6) begin
            numScen++;
        end
        $fclose(fd);
        if (numScen == 0) failRun("the stimulus file holds no scenarios");
        cycleLimit = longint'(numScen) * 4000 * 2 * `SD_CLK_HALF;
        for (int s = 0; s < numScen; s++) runScenario(s);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end
endmodule

//--- sdInit_properties.sv
// Concurrent checks on the SD card initializer
// Bound into the top level, watching the engine handshake, the CMD
// output timing and the final status outputs.
`timescale 1ns/100ps

module sdInitProps (
    input logic clk,
    input logic arstN,
    input logic sdFall,
    input logic sdCmdOut,
    input logic cmdStart,
    input logic busy,
    input logic done,
    input logic err
);
    // CMD output moves only on the clk after a card clock fall
    cmdOutOnFall: assert property (@(posedge clk) disable iff (!arstN)
        $changed(sdCmdOut) |-> $past(sdFall)) else $error("sdCmdOut moved off sdFall");

    startWhileIdle: assert property (@(posedge clk) disable iff (!arstN)
        !(cmdStart && busy)) else $error("cmdStart while busy");

    // Final status is one or the other
    doneXorErr: assert property (@(posedge clk) disable iff (!arstN)
        !(done && err)) else $error("done and err both high");
endmodule

bind sdCardInitializer sdInitProps props0 (
    .clk(clk), .arstN(arstN), .sdFall(sdFall), .sdCmdOut(sdCmdOut),
    .cmdStart(cmdStart), .busy(busy), .done(done), .err(err)
);

//--- sdCardInitializer.sv
// SD card initializer top level
// Runs card identification in SD native mode over the CMD line and
// reports the card's RCA with done, or err if any step fails.

`timescale 1ns/100ps

module sdCardInitializer (
    input  logic        clk,
    input  logic        arstN,
    input  logic        sdCmdIn,
    output logic        sdClk,
    output logic        sdCmdOut,
    output logic        sdCmdOe,
    output logic [15:0] rca,
    output logic        done,
    output logic        err
);
    import sdInitPkg::*;

    logic         sdRise;
    logic         sdFall;
    // Sequencer to engine
    logic         cmdStart;
    cmdIndexT     cmdIndex;
    logic [31:0]  cmdArg;
    respKindT     respKind;
    // Engine to sequencer
    logic         busy;
    logic         cmdDone;
    logic         cmdOk;
    logic [135:0] resp;

    sdClockGen clkGen0 (.clk(clk), .arstN(arstN), .sdClk(sdClk), .sdRise(sdRise), .sdFall(sdFall));

    cmdEngine eng0 (
        .clk(clk), .arstN(arstN), .sdRise(sdRise), .sdFall(sdFall),
        .cmdStart(cmdStart), .cmdIndex(cmdIndex), .cmdArg(cmdArg), .respKind(respKind),
        .sdCmdIn(sdCmdIn), .busy(busy), .cmdDone(cmdDone), .cmdOk(cmdOk), .resp(resp),
        .sdCmdOut(sdCmdOut), .sdCmdOe(sdCmdOe)
    );

    initSequencer seq0 (
        .clk(clk), .arstN(arstN), .busy(busy), .cmdDone(cmdDone), .cmdOk(cmdOk),
        .resp(resp), .cmdStart(cmdStart), .cmdIndex(cmdIndex), .cmdArg(cmdArg),
        .respKind(respKind), .rca(rca), .done(done), .err(err)
    );

endmodule

//--- initSequencer.sv
// SD identification sequencer
// Issues CMD0, CMD8, ACMD41 (retried while the card is busy), CMD2,
// CMD3, CMD7 and ACMD6 through the command engine and checks each reply.
// Ends holding done, or err on the first failed check, until reset.

`timescale 1ns/100ps
`include "sdInit_cfg.svh"

module initSequencer (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 busy,
    input  logic                 cmdDone,
    input  logic                 cmdOk,
    input  logic [135:0]         resp,
    output logic                 cmdStart,
    output sdInitPkg::cmdIndexT  cmdIndex,
    output logic [31:0]          cmdArg,
    output sdInitPkg::respKindT  respKind,
    output logic [15:0]          rca,
    output logic                 done,
    output logic                 err
);
    import sdInitPkg::*;

    seqStateT state;
    // Command issued, waiting for cmdDone
    logic     cmdPending;
    logic     isStep;

    assign isStep = (state != seqDone) && (state != seqFail);

    // ==================================================
    // Command per step, stable until cmdDone
    // ==================================================
    always_comb begin
        cmdIndex = cmd0;
        cmdArg   = 32'h0;
        respKind = respNone;
        case (state)
            seqCmd8:   begin cmdIndex = cmd8;  cmdArg = `ARG_IF_COND; respKind = respShort; end
            seqCmd55a: begin cmdIndex = cmd55; respKind = respShort; end
            seqCmd41:  begin cmdIndex = cmd41; cmdArg = `ARG_OP_COND; respKind = respShortNoCrc; end
            seqCmd2:   begin cmdIndex = cmd2;  respKind = respLong; end
            seqCmd3:   begin cmdIndex = cmd3;  respKind = respShort; end
            seqCmd7:   begin cmdIndex = cmd7;  cmdArg = {rca, 16'h0}; respKind = respShort; end
            seqCmd55b: begin cmdIndex = cmd55; cmdArg = {rca, 16'h0}; respKind = respShort; end
            seqCmd6:   begin cmdIndex = cmd6;  cmdArg = `ARG_BUS_WIDTH4; respKind = respShort; end
            default:   ;
        endcase
    end

    // ==================================================
    // Step FSM
    // ==================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= seqCmd0;
            cmdPending <= 1'b0;
            cmdStart   <= 1'b0;
            rca        <= '0;
            done       <= 1'b0;
            err        <= 1'b0;
        end else begin
            cmdStart <= 1'b0;
            // Launch once per step while the engine is free
            if (isStep && !cmdPending && !busy) begin
                cmdStart   <= 1'b1;
                cmdPending <= 1'b1;
            end
            if (cmdDone && cmdPending) begin
                cmdPending <= 1'b0;
                if (!cmdOk) begin
                    state <= seqFail;
                    err   <= 1'b1;
                end else begin
                    case (state)
                        seqCmd0:   state <= seqCmd8;
                        seqCmd8: begin
                            // Check pattern must come back unchanged
                            if (resp[15:8] == 8'hAA) begin
                                state <= seqCmd55a;
                            end else begin
                                state <= seqFail;
                                err   <= 1'b1;
                            end
                        end
                        seqCmd55a: state <= seqCmd41;
                        seqCmd41: begin
                            // R3 carries all ones in index and CRC fields
                            if ((resp[45:40] != 6'h3F) || (resp[7:1] != 7'h7F)) begin
                                state <= seqFail;
                                err   <= 1'b1;
                            end else if (resp[39]) begin
                                state <= seqCmd2;
                            end else begin
                                // Card still busy, repeat ACMD41
                                state <= seqCmd55a;
                            end
                        end
                        seqCmd2:   state <= seqCmd3;
                        seqCmd3: begin
                            rca   <= resp[39:24];
                            state <= seqCmd7;
                        end
                        seqCmd7:   state <= seqCmd55b;
                        seqCmd55b: state <= seqCmd6;
                        seqCmd6: begin
                            state <= seqDone;
                            done  <= 1'b1;
                        end
                        default:   state <= seqFail;
                    endcase
                end
            end
        end
    end

endmodule

//--- cmdEngine.sv
// SD command engine
// Sends one 48-bit command with hardware CRC7 on the CMD line, then
// optionally receives a 48-bit or 136-bit response and checks it.
// Ends every transaction with the 8 card clock idle gap.
// Handshake is cmdStart in, busy and a cmdDone/cmdOk pulse out.

`timescale 1ns/100ps
`include "sdInit_cfg.svh"

module cmdEngine (
    input  logic                clk,
    input  logic                arstN,
    input  logic                sdRise,
    input  logic                sdFall,
    input  logic                cmdStart,
    input  sdInitPkg::cmdIndexT cmdIndex,
    input  logic [31:0]         cmdArg,
    input  sdInitPkg::respKindT respKind,
    input  logic                sdCmdIn,
    output logic                busy,
    output logic                cmdDone,
    output logic                cmdOk,
    output logic [135:0]        resp,
    output logic                sdCmdOut,
    output logic                sdCmdOe
);
    import sdInitPkg::*;

    // Bit positions within a frame, counted from the start bit
    localparam logic [7:0] CrcStart = 8'(`CMD_BITS - 8);
    localparam logic [7:0] CmdBits  = 8'(`CMD_BITS);
    localparam logic [2:0] GapLast  = 3'(`GAP_CLKS - 1);

    engStateT    state;
    logic [47:0] txShift;
    logic [7:0]  bitCnt;
    logic [2:0]  gapCnt;
    logic        okFlag;
    logic [7:0]  rxLast;
    logic        rxStart;
    logic        crcClear;
    logic [6:0]  txCrc;
    logic [6:0]  rxCrc;

    assign rxLast   = (respKind == respLong) ? 8'(`LONG_RESP_BITS - 1) : 8'(`CMD_BITS - 1);
    // Low start bit seen while waiting
    assign rxStart  = (state == engWaitStart) && !sdCmdIn;
    assign crcClear = (state == engIdle);

    // ==================================================
    // CRC7 over frame bits 47..8
    // ==================================================
    crc7 txCrc0 (
        .clk   (clk),
        .arstN (arstN),
        .clear (crcClear),
        .bitEn (sdFall && (state == engSend) && (bitCnt < CrcStart)),
        .din   (txShift[47]),
        .crc   (txCrc)
    );

    crc7 rxCrc0 (
        .clk   (clk),
        .arstN (arstN),
        .clear (crcClear),
        .bitEn (sdRise && (rxStart || ((state == engRecv) && (bitCnt < CrcStart)))),
        .din   (sdCmdIn),
        .crc   (rxCrc)
    );

    // Frame and response shift registers
    always_ff @(posedge clk) begin
        if ((state == engIdle) && cmdStart) begin
            // Start, transmission bit, index, argument, CRC slot, end bit
            txShift <= {1'b0, 1'b1, cmdIndex, cmdArg, 7'h00, 1'b1};
        end else if ((state == engSend) && sdFall) begin
            if (bitCnt == CrcStart) begin
                // First CRC bit goes out now, the rest replace the slot
                txShift <= {txCrc[5:0], txShift[40:0], 1'b0};
            end else begin
                txShift <= {txShift[46:0], 1'b0};
            end
        end
        if (sdRise && (rxStart || (state == engRecv))) begin
            resp <= {resp[134:0], sdCmdIn};
        end
    end

    // ==================================================
    // Transaction FSM
    // ==================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= engIdle;
            busy     <= 1'b0;
            cmdDone  <= 1'b0;
            cmdOk    <= 1'b0;
            okFlag   <= 1'b0;
            bitCnt   <= '0;
            gapCnt   <= '0;
            sdCmdOut <= 1'b1;
            sdCmdOe  <= 1'b0;
        end else begin
            cmdDone <= 1'b0;
            case (state)
                engIdle: begin
                    if (cmdStart) begin
                        busy   <= 1'b1;
                        okFlag <= 1'b1;
                        bitCnt <= '0;
                        state  <= engSend;
                    end
                end
                engSend: begin
                    if (sdFall) begin
                        if (bitCnt == CmdBits) begin
                            // End bit held one card clock, release the line
                            sdCmdOe  <= 1'b0;
                            sdCmdOut <= 1'b1;
                            bitCnt   <= '0;
                            gapCnt   <= '0;
                            state    <= (respKind == respNone) ? engGap : engWaitStart;
                        end else begin
                            sdCmdOe  <= 1'b1;
                            sdCmdOut <= (bitCnt == CrcStart) ? txCrc[6] : txShift[47];
                            bitCnt   <= bitCnt + 1'b1;
                        end
                    end
                end
                engWaitStart: begin
                    // No timeout, the card sets the pace here
                    if (sdRise && !sdCmdIn) begin
                        bitCnt <= 8'd1;
                        state  <= engRecv;
                    end
                end
                engRecv: begin
                    if (sdRise) begin
                        // Transmission bit must be low for card to host
                        if ((bitCnt == 8'd1) && sdCmdIn) begin
                            okFlag <= 1'b0;
                        end
                        if (bitCnt == rxLast) begin
                            state <= engCheck;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                engCheck: begin
                    // Stop bit, then CRC for plain short responses
                    if (!resp[0] || ((respKind == respShort) && (resp[7:1] != rxCrc))) begin
                        okFlag <= 1'b0;
                    end
                    gapCnt <= '0;
                    state  <= engGap;
                end
                engGap: begin
                    if (sdFall) begin
                        if (gapCnt == GapLast) begin
                            busy    <= 1'b0;
                            cmdDone <= 1'b1;
                            cmdOk   <= okFlag;
                            state   <= engIdle;
                        end else begin
                            gapCnt <= gapCnt + 1'b1;
                        end
                    end
                end
                default: state <= engIdle;
            endcase
        end
    end

endmodule

//--- sdClockGen.sv
// Card clock generator
// Divides clk down to sdClk and marks each sdClk edge with a one-clk
// strobe, so the rest of the design stays on clk with enables.

`timescale 1ns/100ps
`include "sdInit_cfg.svh"

module sdClockGen (
    input  logic clk,
    input  logic arstN,
    output logic sdClk,
    output logic sdRise,
    output logic sdFall
);

    localparam int CntW = $clog2(`SD_CLK_HALF + 1);
    localparam logic [CntW-1:0] CntLast = CntW'(`SD_CLK_HALF - 1);

    // Half period counter
    logic [CntW-1:0] cnt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cnt    <= '0;
            sdClk  <= 1'b0;
            sdRise <= 1'b0;
            sdFall <= 1'b0;
        end else begin
            sdRise <= 1'b0;
            sdFall <= 1'b0;
            if (cnt == CntLast) begin
                cnt    <= '0;
                sdClk  <= !sdClk;
                // Strobe lines up with the new sdClk level
                sdRise <= !sdClk;
                sdFall <= sdClk;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

//--- crc7.sv
// Serial CRC7 for SD command and response frames
// Polynomial x^7 + x^3 + 1, one data bit per enabled clk, MSB first.
// Assert clear before a frame, then pulse bitEn for each covered bit.

`timescale 1ns/100ps

module crc7 (
    input  logic       clk,
    input  logic       arstN,
    input  logic       clear,
    input  logic       bitEn,
    input  logic       din,
    output logic [6:0] crc
);

    // Feedback from the top bit
    logic fb;
    assign fb = din ^ crc[6];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (bitEn) begin
            // x^3 tap folds feedback into bit 3
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

//--- sdInitPkg.sv
// Types shared by the SD card initializer
// Command indexes, response kinds and the state encodings of the
// sequencer and the command engine.

package sdInitPkg;

    // Command indexes used during identification
    typedef enum logic [5:0] {
        cmd0  = 6'd0,
        cmd2  = 6'd2,
        cmd3  = 6'd3,
        cmd6  = 6'd6,
        cmd7  = 6'd7,
        cmd8  = 6'd8,
        cmd41 = 6'd41,
        cmd55 = 6'd55
    } cmdIndexT;

    // What the engine should expect back
    typedef enum logic [1:0] {respNone, respShort, respShortNoCrc, respLong} respKindT;

    // Sequencer steps, one per command
    typedef enum logic [3:0] {
        seqCmd0, seqCmd8, seqCmd55a, seqCmd41, seqCmd2,
        seqCmd3, seqCmd7, seqCmd55b, seqCmd6, seqDone, seqFail
    } seqStateT;

    // Command engine phases
    typedef enum logic [2:0] {
        engIdle, engSend, engWaitStart, engRecv, engCheck, engGap
    } engStateT;

endpackage

//--- sdInit_cfg.svh
// Shared constants for the SD card initializer
// Card clock divider, frame lengths, idle gap and the fixed command arguments.
// Include this file in any module that needs these values.

`ifndef SD_INIT_CFG_SVH
`define SD_INIT_CFG_SVH

// clk cycles per half period of the card clock
`define SD_CLK_HALF 4

// Command frame and short response length
`define CMD_BITS 48
// R2 (CID) response length
`define LONG_RESP_BITS 136

// Idle card clocks after a command or response (NCC / NRC)
`define GAP_CLKS 8

// CMD8: 2.7-3.6V supply, check pattern AA
`define ARG_IF_COND 32'h0000_01AA
// ACMD41: HCS and XPC set, voltage window 0x8000, S18R clear
`define ARG_OP_COND 32'h5000_8000
// ACMD6: 4-bit data bus
`define ARG_BUS_WIDTH4 32'h0000_0002

`endif
